/* design/req_funnel_defines.svh */
`ifndef REQ_FUNNEL_DEFINES_SVH
`define REQ_FUNNEL_DEFINES_SVH

// request word and lane count
`define REQ_DATA_WIDTH 32
`define REQ_LANES 8

// FIFO sizes in address bits
`define LANE_DEPTH_BITS 4
`define OUT_DEPTH_BITS 4

// lane thresholds with six entries of headroom above almost full
`define LANE_AFULL 10
`define LANE_AEMPTY 4

`define OUT_AFULL 10
`define OUT_AEMPTY 2

`endif

/* design/req_word_pkg.sv */
`include "req_funnel_defines.svh"

package req_word_pkg;

  // one request word as it moves from a producer lane to the output stream
  typedef logic [`REQ_DATA_WIDTH-1:0] req_word_t;

  typedef logic [$clog2(`REQ_LANES)-1:0] lane_idx_t; // lane number

endpackage

/* design/arb_ctrl_pkg.sv */
`include "req_funnel_defines.svh"

package arb_ctrl_pkg;

  typedef logic [`REQ_LANES-1:0] lane_mask_t; // one bit per lane

  // mode of the drain logic as seen by the single arbiter
  typedef enum logic [1:0] {
    drain_idle,
    drain_burst,
    drain_single,
    drain_rest
  } drain_state_e;

endpackage

/* design/lane_if.sv */
`timescale 1ns/1ps

// read side of one lane FIFO
interface lane_if;

  logic re;
  logic valid; // one cycle after a read of a non-empty FIFO
  req_word_pkg::req_word_t dout;
  logic empty;
  logic almostempty;

  modport fifo (
    input  re,
    output valid,
    output dout,
    output empty,
    output almostempty
  );

  modport arbiter (
    output re,
    input  valid,
    input  dout,
    input  empty,
    input  almostempty
  );

endinterface

/* design/req_ingress.sv */
`timescale 1ns/1ps
`include "req_funnel_defines.svh"

module req_ingress (
  input  logic clk,
  input  logic rst_reg,
  input  logic [`REQ_LANES-1:0] req_wr_en_in,
  input  logic [`REQ_LANES*`REQ_DATA_WIDTH-1:0] req_wr_data_in,
  input  arb_ctrl_pkg::lane_mask_t lane_almostfull,
  output arb_ctrl_pkg::lane_mask_t lane_we,
  output req_word_pkg::req_word_t lane_din [`REQ_LANES],
  output logic [`REQ_LANES-1:0] req_wr_available_in
);

  // registered write strobes and per-lane available levels
  always_ff @(posedge clk) begin
    if (rst_reg) begin
      lane_we <= '0;
      req_wr_available_in <= '0;
    end else begin
      lane_we <= req_wr_en_in;
      req_wr_available_in <= ~lane_almostfull; // lags the lane count by one cycle
    end
  end

  // split the flat input bus into one word per lane
  always_ff @(posedge clk) begin
    for (int i = 0; i < `REQ_LANES; i++) begin
      lane_din[i] <= req_wr_data_in[i*`REQ_DATA_WIDTH +: `REQ_DATA_WIDTH];
    end
  end

endmodule

/* design/lane_fifo.sv */
`timescale 1ns/1ps

module lane_fifo #(
  parameter int WIDTH = 32,
  parameter int DEPTH_BITS = 4,
  parameter int AFULL = 10,
  parameter int AEMPTY = 4
) (
  input  logic clk,
  input  logic rst_reg,
  input  logic we,
  input  logic [WIDTH-1:0] din,
  input  logic re,
  output logic valid,
  output logic [WIDTH-1:0] dout,
  output logic [DEPTH_BITS:0] count,
  output logic empty,
  output logic full,
  output logic almostfull,
  output logic almostempty
);

  logic [WIDTH-1:0] mem [2**DEPTH_BITS];
  logic [DEPTH_BITS-1:0] wr_ptr;
  logic [DEPTH_BITS-1:0] rd_ptr;
  logic do_write;
  logic do_read;

  assign do_write = we & ~full; // writes into a full buffer are dropped
  assign do_read = re & ~empty;

  assign empty = (count == '0);
  assign full = count[DEPTH_BITS]; // count only reaches the top bit at full depth
  assign almostfull = (count >= AFULL);
  assign almostempty = (count <= AEMPTY);

  always_ff @(posedge clk) begin
    if (rst_reg) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      valid <= 1'b0;
    end else begin
      valid <= do_read;
      if (do_write) wr_ptr <= wr_ptr + 1'b1;
      if (do_read) rd_ptr <= rd_ptr + 1'b1;
      case ({do_write, do_read})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_write) mem[wr_ptr] <= din;
    if (do_read) dout <= mem[rd_ptr]; // dout holds the word until the next read
  end

endmodule

/* design/req_arbiter.sv */
`timescale 1ns/1ps
`include "req_funnel_defines.svh"

module req_arbiter (
  input  logic clk,
  input  logic rst_reg,
  lane_if.arbiter lanes [`REQ_LANES],
  input  logic out_almostfull,
  output logic out_we,
  output req_word_pkg::req_word_t out_din
);

  arb_ctrl_pkg::lane_mask_t lane_valid;
  arb_ctrl_pkg::lane_mask_t lane_empty;
  arb_ctrl_pkg::lane_mask_t lane_almostempty;
  arb_ctrl_pkg::lane_mask_t lane_re;
  req_word_pkg::req_word_t lane_dout [`REQ_LANES];
  arb_ctrl_pkg::lane_mask_t burst_req;
  arb_ctrl_pkg::lane_mask_t single_req;
  req_word_pkg::lane_idx_t burst_ptr;
  req_word_pkg::lane_idx_t single_ptr;
  req_word_pkg::lane_idx_t burst_idx;
  req_word_pkg::lane_idx_t single_idx;
  arb_ctrl_pkg::drain_state_e state;
  logic [1:0] rest_cnt;
  logic single_ok;
  logic sel_valid;
  req_word_pkg::req_word_t sel_dout;

  // first requester at or after the pointer wins
  function automatic req_word_pkg::lane_idx_t rr_pick(arb_ctrl_pkg::lane_mask_t req,
                                                      req_word_pkg::lane_idx_t start);
    req_word_pkg::lane_idx_t idx;
    rr_pick = start;
    for (int i = `REQ_LANES - 1; i >= 0; i--) begin
      idx = start + req_word_pkg::lane_idx_t'(i);
      if (req[idx]) rr_pick = idx;
    end
  endfunction

  for (genvar i = 0; i < `REQ_LANES; i++) begin : gen_lane
    assign lane_valid[i] = lanes[i].valid;
    assign lane_empty[i] = lanes[i].empty;
    assign lane_almostempty[i] = lanes[i].almostempty;
    assign lane_dout[i] = lanes[i].dout;
    assign lanes[i].re = lane_re[i];
  end

  assign burst_req = ~lane_almostempty & {`REQ_LANES{~out_almostfull}};
  assign single_req = ~lane_empty & {`REQ_LANES{~out_almostfull}};
  assign burst_idx = rr_pick(burst_req, burst_ptr);
  assign single_idx = rr_pick(single_req, single_ptr);
  assign single_ok = (state == arb_ctrl_pkg::drain_idle) || (state == arb_ctrl_pkg::drain_burst);

  always_ff @(posedge clk) begin
    if (rst_reg) begin
      lane_re <= '0;
      burst_ptr <= '0;
      single_ptr <= '0;
      state <= arb_ctrl_pkg::drain_idle;
      rest_cnt <= '0;
    end else begin
      lane_re <= '0;
      if (|burst_req) begin
        lane_re[burst_idx] <= 1'b1; // burst grants may repeat every cycle
        burst_ptr <= burst_idx + 1'b1;
      end else if (|single_req && single_ok) begin
        lane_re[single_idx] <= 1'b1;
        single_ptr <= single_idx + 1'b1;
      end
      case (state)
        arb_ctrl_pkg::drain_single, arb_ctrl_pkg::drain_rest: begin
          // no single grant for two cycles after one was issued
          rest_cnt <= rest_cnt - 2'd1;
          if (rest_cnt == 2'd1) begin
            state <= (|burst_req) ? arb_ctrl_pkg::drain_burst : arb_ctrl_pkg::drain_idle;
          end else begin
            state <= arb_ctrl_pkg::drain_rest;
          end
        end
        default: begin
          if (|burst_req) begin
            state <= arb_ctrl_pkg::drain_burst;
          end else if (|single_req) begin
            state <= arb_ctrl_pkg::drain_single;
            rest_cnt <= 2'd2;
          end else begin
            state <= arb_ctrl_pkg::drain_idle;
          end
        end
      endcase
    end
  end

  // at most one lane reads per cycle so the valids are one-hot
  always_comb begin
    sel_valid = |lane_valid;
    sel_dout = '0;
    for (int i = `REQ_LANES - 1; i >= 0; i--) begin
      if (lane_valid[i]) sel_dout = lane_dout[i];
    end
  end

  always_ff @(posedge clk) begin
    if (rst_reg) out_we <= 1'b0;
    else out_we <= sel_valid;
  end

  always_ff @(posedge clk) begin
    out_din <= sel_dout;
  end

endmodule

/* design/req_egress.sv */
`timescale 1ns/1ps
`include "req_funnel_defines.svh"

module req_egress (
  input  logic clk,
  input  logic rst_reg,
  input  logic out_we,
  input  req_word_pkg::req_word_t out_din,
  output logic out_almostfull,
  input  logic req_wr_available_out,
  output logic req_wr_en_out,
  output req_word_pkg::req_word_t req_wr_data_out
);

  logic out_re;
  logic out_valid;
  req_word_pkg::req_word_t out_dout;
  logic out_empty;
  logic out_almostempty;

  lane_fifo #(
    .WIDTH(`REQ_DATA_WIDTH),
    .DEPTH_BITS(`OUT_DEPTH_BITS),
    .AFULL(`OUT_AFULL),
    .AEMPTY(`OUT_AEMPTY)
  ) out_fifo (
    .clk(clk),
    .rst_reg(rst_reg),
    .we(out_we),
    .din(out_din),
    .re(out_re),
    .valid(out_valid),
    .dout(out_dout),
    .count(),
    .empty(out_empty),
    .full(),
    .almostfull(out_almostfull),
    .almostempty(out_almostempty)
  );

  always_ff @(posedge clk) begin
    if (rst_reg) begin
      out_re <= 1'b0;
      req_wr_en_out <= 1'b0;
    end else begin
      // near empty only every other cycle, so the count can catch up
      if (out_almostempty) out_re <= req_wr_available_out & ~out_empty & ~out_re;
      else out_re <= req_wr_available_out;
      req_wr_en_out <= out_valid;
    end
  end

  always_ff @(posedge clk) begin
    req_wr_data_out <= out_dout;
  end

endmodule

/* design/req_funnel_top.sv */
`timescale 1ns/1ps
`include "req_funnel_defines.svh"

module req_funnel_top (
  input  logic clk,
  input  logic rst,
  input  logic [`REQ_LANES-1:0] req_wr_en_in,
  input  logic [`REQ_LANES*`REQ_DATA_WIDTH-1:0] req_wr_data_in,
  output logic [`REQ_LANES-1:0] req_wr_available_in,
  input  logic req_wr_available_out,
  output logic req_wr_en_out,
  output logic [`REQ_DATA_WIDTH-1:0] req_wr_data_out
);

  logic rst_reg;
  arb_ctrl_pkg::lane_mask_t lane_we;
  arb_ctrl_pkg::lane_mask_t lane_almostfull;
  req_word_pkg::req_word_t lane_din [`REQ_LANES];
  logic out_we;
  req_word_pkg::req_word_t out_din;
  logic out_almostfull;

  lane_if lanes [`REQ_LANES] ();

  always_ff @(posedge clk) begin
    rst_reg <= rst; // everything below resets on this registered copy
  end

  req_ingress ingress (
    .clk(clk),
    .rst_reg(rst_reg),
    .req_wr_en_in(req_wr_en_in),
    .req_wr_data_in(req_wr_data_in),
    .lane_almostfull(lane_almostfull),
    .lane_we(lane_we),
    .lane_din(lane_din),
    .req_wr_available_in(req_wr_available_in)
  );

  for (genvar i = 0; i < `REQ_LANES; i++) begin : gen_lane_fifo
    lane_fifo #(
      .WIDTH(`REQ_DATA_WIDTH),
      .DEPTH_BITS(`LANE_DEPTH_BITS),
      .AFULL(`LANE_AFULL),
      .AEMPTY(`LANE_AEMPTY)
    ) in_fifo (
      .clk(clk),
      .rst_reg(rst_reg),
      .we(lane_we[i]),
      .din(lane_din[i]),
      .re(lanes[i].re),
      .valid(lanes[i].valid),
      .dout(lanes[i].dout),
      .count(),
      .empty(lanes[i].empty),
      .full(),
      .almostfull(lane_almostfull[i]),
      .almostempty(lanes[i].almostempty)
    );
  end

  req_arbiter arbiter (
    .clk(clk),
    .rst_reg(rst_reg),
    .lanes(lanes),
    .out_almostfull(out_almostfull),
    .out_we(out_we),
    .out_din(out_din)
  );

  req_egress egress (
    .clk(clk),
    .rst_reg(rst_reg),
    .out_we(out_we),
    .out_din(out_din),
    .out_almostfull(out_almostfull),
    .req_wr_available_out(req_wr_available_out),
    .req_wr_en_out(req_wr_en_out),
    .req_wr_data_out(req_wr_data_out)
  );

endmodule

/* verif/req_funnel_checker.sv */
`timescale 1ns/1ps
`include "req_funnel_defines.svh"

module req_funnel_checker (
  input  logic clk,
  input  logic rst,
  input  logic [`REQ_LANES-1:0] req_wr_en_in,
  input  logic [`REQ_LANES*`REQ_DATA_WIDTH-1:0] req_wr_data_in,
  input  logic [`REQ_LANES-1:0] req_wr_available_in,
  input  logic req_wr_available_out,
  input  logic req_wr_en_out,
  input  logic [`REQ_DATA_WIDTH-1:0] req_wr_data_out,
  input  int expected_total,
  input  logic finish_req,
  output int errors,
  output int checks,
  output int out_count,
  output logic final_done
);

  localparam int LANES = `REQ_LANES;
  localparam int DW = `REQ_DATA_WIDTH;
  localparam int QDEPTH = 256;
  localparam int FAIR_LEVEL = 12; // enough pending that the lane stays above almost empty
  localparam int FAIR_LIMIT = 8;

  logic [DW-1:0] exp_mem [LANES][QDEPTH];
  int head [LANES];
  int tail [LANES];
  int others [LANES];
  logic armed [LANES];
  int accepted [LANES];
  logic fell [LANES];
  int post_cnt;
  int blk_age;
  int ln;
  logic [DW-1:0] word;

  task automatic report_mismatch(input string name, input logic [63:0] expv,
                                 input logic [63:0] gotv);
    $display("[ERROR] %s expected %0h got %0h", name, expv, gotv);
    errors++;
  endtask

  task automatic report_problem(input string what);
    $display("%s", what);
    errors++;
  endtask

  always @(posedge clk) begin
    if (rst) begin
      errors = 0;
      checks = 0;
      out_count = 0;
      final_done = 1'b0;
      post_cnt = 0;
      blk_age = 0;
      for (int i = 0; i < LANES; i++) begin
        head[i] = 0;
        tail[i] = 0;
        others[i] = 0;
        armed[i] = 1'b0;
        accepted[i] = 0;
        fell[i] = 1'b0;
      end
    end else begin
      post_cnt++;
      if (post_cnt <= 3 && req_wr_en_out !== 1'b0)
        report_mismatch("req_wr_en_out", 64'h0, 64'(req_wr_en_out));
      if (post_cnt == 1 && req_wr_available_in !== '0)
        report_mismatch("req_wr_available_in", 64'h0, 64'(req_wr_available_in));
      if (post_cnt == 3) begin
        checks++;
        if (req_wr_available_in !== '1)
          report_mismatch("req_wr_available_in", 64'hff, 64'(req_wr_available_in));
      end

      if (!req_wr_available_out) begin
        if (blk_age == 0) begin
          for (int i = 0; i < LANES; i++) begin
            accepted[i] = 0;
            fell[i] = 1'b0;
          end
        end
        blk_age++;
        // two pulses may still follow the cycle in which the level fell
        if (blk_age > 3 && req_wr_en_out)
          report_problem("req_wr_en_out kept pulsing during a block");
        for (int i = 0; i < LANES; i++) if (!req_wr_available_in[i]) fell[i] = 1'b1;
      end else begin
        blk_age = 0;
      end

      for (int i = 0; i < LANES; i++) begin
        if (req_wr_en_in[i]) begin
          exp_mem[i][tail[i] % QDEPTH] = req_wr_data_in[i*DW +: DW];
          tail[i]++;
          if (!req_wr_available_out) begin
            accepted[i]++;
            if (accepted[i] > 16 && !fell[i]) begin
              report_problem($sformatf("lane %0d took over 16 words in a block", i));
              fell[i] = 1'b1;
            end
          end
        end
      end

      if (req_wr_en_out) begin
        checks++;
        ln = int'(req_wr_data_out[DW-1:DW-8]);
        if (ln >= LANES) begin
          report_mismatch("req_wr_data_out lane field", 64'(LANES - 1), 64'(ln));
        end else if (head[ln] == tail[ln]) begin
          report_problem($sformatf("word %0h left lane %0d with nothing pending",
                                   req_wr_data_out, ln));
        end else begin
          word = exp_mem[ln][head[ln] % QDEPTH];
          head[ln]++;
          if (word !== req_wr_data_out)
            report_mismatch("req_wr_data_out", 64'(word), 64'(req_wr_data_out));
          for (int i = 0; i < LANES; i++) begin
            if (i != ln && armed[i]) begin
              others[i]++;
              if (others[i] > FAIR_LIMIT) begin
                report_problem($sformatf("lane %0d waited behind too many words", i));
                armed[i] = 1'b0;
              end
            end
          end
          others[ln] = 0;
          armed[ln] = (tail[ln] - head[ln] >= FAIR_LEVEL);
        end
        out_count++;
      end

      if (finish_req && !final_done) begin
        checks++;
        if (out_count != expected_total)
          report_mismatch("output word total", 64'(expected_total), 64'(out_count));
        for (int i = 0; i < LANES; i++)
          if (head[i] != tail[i])
            report_problem($sformatf("lane %0d never delivered %0d words", i, tail[i] - head[i]));
        if (req_wr_available_in !== '1)
          report_mismatch("req_wr_available_in", 64'hff, 64'(req_wr_available_in));
        final_done = 1'b1;
      end
    end
  end

endmodule

/* verif/req_funnel_tb.sv */
`timescale 1ns/1ps
`include "req_funnel_defines.svh"

module req_funnel_tb;

  localparam int LANES = `REQ_LANES;
  localparam int DW = `REQ_DATA_WIDTH;
  localparam int REC_MAX = 64;

  logic clk = 1'b0;
  logic rst;
  logic [LANES-1:0] req_wr_en_in;
  logic [LANES*DW-1:0] req_wr_data_in;
  logic [LANES-1:0] req_wr_available_in;
  logic req_wr_available_out = 1'b1;
  logic req_wr_en_out;
  logic [DW-1:0] req_wr_data_out;

  logic [31:0] records [REC_MAX];
  logic [31:0] rand_state;
  int seq [LANES];
  int cycle = 0;
  int limit = 0;
  int blk_end = 0;
  int expected_total;
  int words;
  int waits;
  int tests;
  int r;
  int lane;
  logic finish_req;
  logic final_done;
  int errors;
  int checks;
  int out_count;

  req_funnel_top req_funnel_top_inst (
    .clk(clk),
    .rst(rst),
    .req_wr_en_in(req_wr_en_in),
    .req_wr_data_in(req_wr_data_in),
    .req_wr_available_in(req_wr_available_in),
    .req_wr_available_out(req_wr_available_out),
    .req_wr_en_out(req_wr_en_out),
    .req_wr_data_out(req_wr_data_out)
  );

  req_funnel_checker watch (
    .clk(clk),
    .rst(rst),
    .req_wr_en_in(req_wr_en_in),
    .req_wr_data_in(req_wr_data_in),
    .req_wr_available_in(req_wr_available_in),
    .req_wr_available_out(req_wr_available_out),
    .req_wr_en_out(req_wr_en_out),
    .req_wr_data_out(req_wr_data_out),
    .expected_total(expected_total),
    .finish_req(finish_req),
    .errors(errors),
    .checks(checks),
    .out_count(out_count),
    .final_done(final_done)
  );

  always #50 clk = ~clk;

  // the downstream level is low until the current block window runs out
  always @(posedge clk) begin
    cycle <= cycle + 1;
    req_wr_available_out <= (cycle >= blk_end);
    if (limit != 0 && cycle > limit) begin
      $display("timeout: the run did not finish within %0d cycles", limit);
      $display("Test failed");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // writes one lane and waits on its available level before each word
  task automatic send_burst(input int ln, input int n);
    int sent;
    sent = 0;
    while (sent < n) begin
      @(posedge clk);
      if (req_wr_available_in[ln]) begin
        req_wr_en_in[ln] <= 1'b1;
        req_wr_data_in[ln*DW +: DW] <= {8'(ln), 24'(seq[ln])};
        seq[ln] = seq[ln] + 1;
        sent++;
      end else begin
        req_wr_en_in[ln] <= 1'b0;
      end
    end
    @(posedge clk);
    req_wr_en_in <= '0;
  endtask

  task automatic send_all(input int n);
    int sent [LANES];
    int done;
    done = 0;
    for (int i = 0; i < LANES; i++) sent[i] = 0;
    while (done < LANES) begin
      @(posedge clk);
      done = 0;
      for (int i = 0; i < LANES; i++) begin
        if (sent[i] < n && req_wr_available_in[i]) begin
          req_wr_en_in[i] <= 1'b1;
          req_wr_data_in[i*DW +: DW] <= {8'(i), 24'(seq[i])};
          seq[i] = seq[i] + 1;
          sent[i]++;
        end else begin
          req_wr_en_in[i] <= 1'b0;
        end
        if (sent[i] >= n) done++;
      end
    end
    @(posedge clk);
    req_wr_en_in <= '0;
  endtask

  initial begin
    rst = 1'b1;
    req_wr_en_in = '0;
    req_wr_data_in = '0;
    finish_req = 1'b0;
    rand_state = 32'he6e094be;
    tests = 0;
    words = 0;
    waits = 0;
    expected_total = 0;
    for (int i = 0; i < LANES; i++) seq[i] = 0;
    for (int i = 0; i < REC_MAX; i++) records[i] = '0;
    $readmemh("verif/req_funnel_input.txt", records);

    // kind in the top nibble, count or cycles in the low half
    r = 0;
    while (r < REC_MAX && records[r][31:28] != 4'h0) begin
      case (records[r][31:28])
        4'h1: words += int'(records[r][15:0]);
        4'h2: words += int'(records[r][15:0]) * LANES;
        4'h3, 4'h4: waits += int'(records[r][15:0]);
        4'hf: expected_total = int'(records[r][15:0]);
        default: ;
      endcase
      r++;
    end
    limit = 20 * words + waits + 200;

    repeat (8) @(posedge clk);
    rst <= 1'b0;
    repeat (4) @(posedge clk);
    tests++;
    $display("test %0d: reset values checked", tests);

    r = 0;
    while (r < REC_MAX && records[r][31:28] != 4'h0) begin
      case (records[r][31:28])
        4'h1: begin
          lane = int'(records[r][27:24]);
          if (lane >= LANES) begin
            rand_state = lcg_next(rand_state);
            lane = int'(rand_state[30:28]);
          end
          send_burst(lane, int'(records[r][15:0]));
          tests++;
          $display("test %0d: %0d words to lane %0d done", tests, records[r][15:0], lane);
        end
        4'h2: begin
          send_all(int'(records[r][15:0]));
          tests++;
          $display("test %0d: %0d words to every lane done", tests, records[r][15:0]);
        end
        4'h3: begin
          blk_end <= cycle + int'(records[r][15:0]);
          tests++;
          $display("test %0d: output block of %0d cycles started", tests, records[r][15:0]);
        end
        4'h4: repeat (int'(records[r][15:0])) @(posedge clk);
        default: ;
      endcase
      r++;
    end

    while (out_count < expected_total) @(posedge clk);
    repeat (4) @(posedge clk);
    finish_req <= 1'b1;
    while (!final_done) @(posedge clk);
    tests++;
    $display("test %0d: output total and final levels checked", tests);
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) $display("Test completed successfully");
    else $display("Test failed");
    $finish;
  end

endmodule

/* verif/req_funnel_input.txt */
// kind[31:28] 1 burst, 2 burst to every lane, 3 output block, 4 idle, f expected total
// lane[27:24] (8 picks a random lane), words or cycles in [15:0]
10000006 // lane 0
13000003 // lane 3
18000005 // random lane
18000004 // random lane
40000020
30000030 // short block with traffic
11000008
16000007
40000040
3000012c // long block
1500000c // fills the output FIFO
12000014 // long burst that must stall on its available level
40000180
20000018 // every lane loaded for round-robin
40000100
18000006
18000003
40000080
f000010a // 266 words in total
00000000

/* src.f */
+incdir+design
design/req_word_pkg.sv
design/arb_ctrl_pkg.sv
design/lane_if.sv
design/req_ingress.sv
design/lane_fifo.sv
design/req_arbiter.sv
design/req_egress.sv
design/req_funnel_top.sv
verif/req_funnel_checker.sv
verif/req_funnel_tb.sv

/* run.sh */
#!/bin/sh
rm -f sim.log
verilator --binary --timing -f src.f --top-module req_funnel_tb -o req_funnel_sim > build.log 2>&1 &&
  ./obj_dir/req_funnel_sim > sim.log 2>&1 ||
  echo "build or simulation did not complete" >> sim.log
grep -q "Test failed" sim.log && exit 1
grep -q "Test completed successfully" sim.log || exit 1
exit 0
